// ==== hdl/swu_flow_ctrl.sv ====
`timescale 1ns/100ps

module swu_flow_ctrl
   import swu_pkg::*;
#(
   parameter int SIMD         = DEF_SIMD,
   parameter int IFM_CHANNELS = DEF_IFM_CHANNELS,
   parameter int IFM_WIDTH    = DEF_IFM_WIDTH,
   parameter int IFM_HEIGHT   = DEF_IFM_HEIGHT,
   parameter int KERNEL_DIM   = DEF_KERNEL_DIM,
   parameter int STRIDE       = DEF_STRIDE
) (
   input  logic   aclk,
   input  logic   aresetn,
   input  logic   s_axis_tvalid_i,
   output logic   s_axis_tready_o,
   output logic   wr_en_o,
   output index_t wr_addr_o,
   input  index_t needed_pos_i,
   input  index_t oldest_pos_i,
   input  logic   frame_done_i,
   output index_t beats_written_o,
   output logic   data_ready_o
);

   localparam int GROUPS = ch_groups(IFM_CHANNELS, SIMD);

   localparam index_t FRAME_BEATS = index_t'(IFM_HEIGHT * IFM_WIDTH * GROUPS);
   localparam index_t DEPTH       =
      index_t'(buffer_beats(KERNEL_DIM, STRIDE, IFM_WIDTH, GROUPS));

   index_t beats_written;
   index_t wr_addr;
   index_t occupancy;
   logic   written_all;
   logic   reads_done;
   logic   restart;

   assign written_all = (beats_written == FRAME_BEATS);

   // the reader can be ahead of the writer when the kernel is smaller than the stride
   assign occupancy = (beats_written > oldest_pos_i) ? beats_written - oldest_pos_i : '0;

   ////////////////////////////////////////////////////////////
   // input side
   ////////////////////////////////////////////////////////////

   // once all reads of the frame are done, the tail of the frame is just drained
   assign s_axis_tready_o = !written_all && (reads_done || (occupancy < DEPTH));
   assign wr_en_o         = s_axis_tvalid_i && s_axis_tready_o;
   assign wr_addr_o       = wr_addr;
   assign beats_written_o = beats_written;

   // reads wait for their beat; nothing of a finished frame is read again
   assign data_ready_o = !reads_done && (beats_written > needed_pos_i);

   // both sides of the frame finished
   assign restart = written_all && (reads_done || frame_done_i);

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         beats_written <= '0;
         wr_addr       <= '0;
         reads_done    <= 1'b0;
      end else if (restart) begin
         beats_written <= '0;
         wr_addr       <= '0;
         reads_done    <= 1'b0;
      end else begin
         if (wr_en_o) begin
            beats_written <= beats_written + index_t'(1);
            wr_addr       <= (wr_addr == DEPTH - index_t'(1)) ? '0 : wr_addr + index_t'(1);
         end
         // last read can come before the last write
         if (frame_done_i) begin
            reads_done <= 1'b1;
         end
      end
   end

endmodule

// ==== hdl/swu_line_buffer.sv ====
`timescale 1ns/100ps

module swu_line_buffer
   import swu_pkg::*;
#(
   parameter int BEAT_BITS = 24,
   parameter int DEPTH     = 56
) (
   input  logic                 aclk,
   input  logic                 wr_en_i,
   input  index_t               wr_addr_i,
   input  logic [BEAT_BITS-1:0] wr_data_i,
   input  logic                 rd_en_i,
   input  index_t               rd_addr_i,
   output logic [BEAT_BITS-1:0] rd_data_o
);

   // address bits actually decoded by the memory
   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   logic [BEAT_BITS-1:0] mem [DEPTH];
   logic [AW-1:0]        wr_idx;
   logic [AW-1:0]        rd_idx;

   // addresses come in already wrapped to DEPTH
   assign wr_idx = wr_addr_i[AW-1:0];
   assign rd_idx = rd_addr_i[AW-1:0];

   ////////////////////////////////////////////////////////////
   // write port
   ////////////////////////////////////////////////////////////

   always_ff @(posedge aclk) begin
      if (wr_en_i) begin
         mem[wr_idx] <= wr_data_i;
      end
   end

   ////////////////////////////////////////////////////////////
   // registered read port, holds its value between reads
   ////////////////////////////////////////////////////////////

   always_ff @(posedge aclk) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_idx];
      end
   end

endmodule

// ==== hdl/swu_output_stage.sv ====
`timescale 1ns/100ps

module swu_output_stage #(
   parameter int BEAT_BITS = 24
) (
   input  logic                 aclk,
   input  logic                 aresetn,
   input  logic                 rd_en_i,
   input  logic [BEAT_BITS-1:0] rd_data_i,
   input  logic                 m_axis_tready_i,
   output logic                 m_axis_tvalid_o,
   output logic [BEAT_BITS-1:0] m_axis_tdata_o,
   output logic                 can_issue_o
);

   // stage r is the memory output register, stage q drives the stream
   logic                 r_valid;
   logic                 q_valid;
   logic [BEAT_BITS-1:0] q_data;
   logic                 q_free;

   assign q_free      = !q_valid || m_axis_tready_i;
   assign can_issue_o = !r_valid || q_free;

   assign m_axis_tvalid_o = q_valid;
   assign m_axis_tdata_o  = q_data;

   ////////////////////////////////////////////////////////////
   // valid bits
   ////////////////////////////////////////////////////////////

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         r_valid <= 1'b0;
         q_valid <= 1'b0;
      end else begin
         // r refills only when its beat moves on or it was empty
         if (can_issue_o) begin
            r_valid <= rd_en_i;
         end
         if (q_free) begin
            q_valid <= r_valid;
         end
      end
   end

   // payload follows r into q
   always_ff @(posedge aclk) begin
      if (q_free && r_valid) begin
         q_data <= rd_data_i;
      end
   end

endmodule

// ==== hdl/swu_pkg.sv ====
package swu_pkg;

   ////////////////////////////////////////////////////////////
   // default geometry
   ////////////////////////////////////////////////////////////

   localparam int DEF_SIMD         = 3;
   localparam int DEF_PRECISION    = 8;
   localparam int DEF_IFM_CHANNELS = 6;
   localparam int DEF_IFM_WIDTH    = 7;
   localparam int DEF_IFM_HEIGHT   = 7;
   localparam int DEF_KERNEL_DIM   = 3;
   localparam int DEF_STRIDE       = 2;

   // beat counts and absolute beat positions within one frame
   typedef logic [15:0] index_t;

   ////////////////////////////////////////////////////////////
   // derived sizes
   ////////////////////////////////////////////////////////////

   // beats per pixel
   function automatic int ch_groups(int ifm_channels, int simd);
      return ifm_channels / simd;
   endfunction

   // output rows or columns for one input dimension
   function automatic int ofm_dim(int ifm_dim, int kernel_dim, int stride);
      return (ifm_dim - kernel_dim) / stride + 1;
   endfunction

   // line buffer holds kernel rows plus the rows one stride step brings in
   function automatic int buffer_beats(int kernel_dim, int stride, int ifm_width,
                                       int groups);
      return (kernel_dim + stride - 1) * ifm_width * groups;
   endfunction

endpackage

// ==== hdl/swu_top.sv ====
`timescale 1ns/100ps

module swu_top
   import swu_pkg::*;
#(
   parameter int SIMD         = DEF_SIMD,
   parameter int IP_PRECISION = DEF_PRECISION,
   parameter int IFM_CHANNELS = DEF_IFM_CHANNELS,
   parameter int IFM_WIDTH    = DEF_IFM_WIDTH,
   parameter int IFM_HEIGHT   = DEF_IFM_HEIGHT,
   parameter int KERNEL_DIM   = DEF_KERNEL_DIM,
   parameter int STRIDE       = DEF_STRIDE
) (
   input  logic                         aclk,
   input  logic                         aresetn,
   input  logic [SIMD*IP_PRECISION-1:0] s_axis_tdata_i,
   input  logic                         s_axis_tvalid_i,
   output logic                         s_axis_tready_o,
   output logic [SIMD*IP_PRECISION-1:0] m_axis_tdata_o,
   output logic                         m_axis_tvalid_o,
   input  logic                         m_axis_tready_i
);

   localparam int BEAT_BITS = SIMD * IP_PRECISION;
   localparam int DEPTH     =
      buffer_beats(KERNEL_DIM, STRIDE, IFM_WIDTH, ch_groups(IFM_CHANNELS, SIMD));

   logic                 wr_en;
   index_t               wr_addr;
   logic                 rd_en;
   index_t               rd_addr;
   logic [BEAT_BITS-1:0] rd_data;
   index_t               needed_pos;
   index_t               oldest_pos;
   logic                 data_ready;
   logic                 can_issue;
   logic                 frame_done;

   swu_flow_ctrl #(
      .SIMD(SIMD), .IFM_CHANNELS(IFM_CHANNELS), .IFM_WIDTH(IFM_WIDTH),
      .IFM_HEIGHT(IFM_HEIGHT), .KERNEL_DIM(KERNEL_DIM), .STRIDE(STRIDE)
   ) flow_ctrl_i (
      .aclk(aclk), .aresetn(aresetn),
      .s_axis_tvalid_i(s_axis_tvalid_i), .s_axis_tready_o(s_axis_tready_o),
      .wr_en_o(wr_en), .wr_addr_o(wr_addr),
      .needed_pos_i(needed_pos), .oldest_pos_i(oldest_pos), .frame_done_i(frame_done),
      .beats_written_o(), .data_ready_o(data_ready)
   );

   swu_line_buffer #(.BEAT_BITS(BEAT_BITS), .DEPTH(DEPTH)) line_buffer_i (
      .aclk(aclk),
      .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(s_axis_tdata_i),
      .rd_en_i(rd_en), .rd_addr_i(rd_addr), .rd_data_o(rd_data)
   );

   swu_window_counter #(
      .SIMD(SIMD), .IFM_CHANNELS(IFM_CHANNELS), .IFM_WIDTH(IFM_WIDTH),
      .IFM_HEIGHT(IFM_HEIGHT), .KERNEL_DIM(KERNEL_DIM), .STRIDE(STRIDE)
   ) window_counter_i (
      .aclk(aclk), .aresetn(aresetn),
      .can_issue_i(can_issue), .data_ready_i(data_ready),
      .rd_en_o(rd_en), .rd_addr_o(rd_addr),
      .needed_pos_o(needed_pos), .oldest_pos_o(oldest_pos), .frame_done_o(frame_done)
   );

   swu_output_stage #(.BEAT_BITS(BEAT_BITS)) output_stage_i (
      .aclk(aclk), .aresetn(aresetn),
      .rd_en_i(rd_en), .rd_data_i(rd_data),
      .m_axis_tready_i(m_axis_tready_i), .m_axis_tvalid_o(m_axis_tvalid_o),
      .m_axis_tdata_o(m_axis_tdata_o), .can_issue_o(can_issue)
   );

endmodule

// ==== hdl/swu_window_counter.sv ====
`timescale 1ns/100ps

module swu_window_counter
   import swu_pkg::*;
#(
   parameter int SIMD         = DEF_SIMD,
   parameter int IFM_CHANNELS = DEF_IFM_CHANNELS,
   parameter int IFM_WIDTH    = DEF_IFM_WIDTH,
   parameter int IFM_HEIGHT   = DEF_IFM_HEIGHT,
   parameter int KERNEL_DIM   = DEF_KERNEL_DIM,
   parameter int STRIDE       = DEF_STRIDE
) (
   input  logic   aclk,
   input  logic   aresetn,
   input  logic   can_issue_i,
   input  logic   data_ready_i,
   output logic   rd_en_o,
   output index_t rd_addr_o,
   output index_t needed_pos_o,
   output index_t oldest_pos_o,
   output logic   frame_done_o
);

   localparam int GROUPS = ch_groups(IFM_CHANNELS, SIMD);
   localparam int DEPTH  = buffer_beats(KERNEL_DIM, STRIDE, IFM_WIDTH, GROUPS);

   localparam index_t DEPTH_I   = index_t'(DEPTH);
   localparam index_t ONE       = index_t'(1);
   localparam index_t ROW_STEP  = index_t'(IFM_WIDTH * GROUPS);
   localparam index_t COL_STEP  = index_t'(STRIDE * GROUPS);
   localparam index_t LINE_STEP = index_t'(STRIDE * IFM_WIDTH * GROUPS);
   localparam index_t LAST_CG   = index_t'(GROUPS - 1);
   localparam index_t LAST_K    = index_t'(KERNEL_DIM - 1);
   localparam index_t LAST_OX   = index_t'(ofm_dim(IFM_WIDTH, KERNEL_DIM, STRIDE) - 1);
   localparam index_t LAST_OY   = index_t'(ofm_dim(IFM_HEIGHT, KERNEL_DIM, STRIDE) - 1);

   // counters, innermost first
   index_t cg, kw, kh, ox, oy;

   // absolute positions: current beat, kernel row start, window start, oldest row
   index_t pos, kh_base, col_base, row_base;
   // the same positions modulo DEPTH
   index_t pos_w, kh_w, col_w, row_w;

   logic   row_end, win_end, line_end, frame_end;
   index_t jump, jump_w;

   // step of less than DEPTH on a wrapped address
   function automatic index_t wrap_add(index_t a, index_t b);
      index_t sum;
      sum = a + b;
      return (sum >= DEPTH_I) ? sum - DEPTH_I : sum;
   endfunction

   assign row_end   = (cg == LAST_CG) && (kw == LAST_K);
   assign win_end   = row_end && (kh == LAST_K);
   assign line_end  = win_end && (ox == LAST_OX);
   assign frame_end = line_end && (oy == LAST_OY);

   assign rd_en_o      = can_issue_i && data_ready_i;
   assign frame_done_o = rd_en_o && frame_end;
   assign needed_pos_o = pos;
   assign rd_addr_o    = pos_w;
   assign oldest_pos_o = row_base;

   // start of the next kernel row, window or output line
   always_comb begin
      if (line_end) begin
         jump   = row_base + LINE_STEP;
         jump_w = wrap_add(row_w, LINE_STEP);
      end else if (win_end) begin
         jump   = col_base + COL_STEP;
         jump_w = wrap_add(col_w, COL_STEP);
      end else begin
         jump   = kh_base + ROW_STEP;
         jump_w = wrap_add(kh_w, ROW_STEP);
      end
   end

   ////////////////////////////////////////////////////////////
   // advance on every read
   ////////////////////////////////////////////////////////////

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         cg       <= '0;
         kw       <= '0;
         kh       <= '0;
         ox       <= '0;
         oy       <= '0;
         pos      <= '0;
         kh_base  <= '0;
         col_base <= '0;
         row_base <= '0;
         pos_w    <= '0;
         kh_w     <= '0;
         col_w    <= '0;
         row_w    <= '0;
      end else if (rd_en_o) begin
         cg <= (cg == LAST_CG) ? '0 : cg + ONE;
         if (cg == LAST_CG) begin
            kw <= (kw == LAST_K) ? '0 : kw + ONE;
         end
         if (row_end) begin
            kh <= (kh == LAST_K) ? '0 : kh + ONE;
         end
         if (win_end) begin
            ox <= (ox == LAST_OX) ? '0 : ox + ONE;
         end
         if (line_end) begin
            oy <= (oy == LAST_OY) ? '0 : oy + ONE;
         end

         if (frame_end) begin
            // next frame starts at position zero
            pos      <= '0;
            kh_base  <= '0;
            col_base <= '0;
            row_base <= '0;
            pos_w    <= '0;
            kh_w     <= '0;
            col_w    <= '0;
            row_w    <= '0;
         end else begin
            // kw and cg walk contiguous beats within a kernel row
            if (row_end) begin
               pos     <= jump;
               pos_w   <= jump_w;
               kh_base <= jump;
               kh_w    <= jump_w;
            end else begin
               pos   <= pos + ONE;
               pos_w <= wrap_add(pos_w, ONE);
            end
            if (win_end) begin
               col_base <= jump;
               col_w    <= jump_w;
            end
            if (line_end) begin
               row_base <= jump;
               row_w    <= jump_w;
            end
         end
      end
   end

endmodule

// ==== project.f ====
hdl/swu_pkg.sv
hdl/swu_line_buffer.sv
hdl/swu_window_counter.sv
hdl/swu_flow_ctrl.sv
hdl/swu_output_stage.sv
hdl/swu_top.sv
tests/swu_chk.sv
tests/swu_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f project.f --top-module swu_tb -o swu_sim || exit 1
out=$(./obj_dir/swu_sim 2>&1)
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED" && echo "run ok" || { echo "run failed"; exit 1; }

// ==== tests/swu_chk.sv ====
`timescale 1ns/100ps

module swu_chk
   import swu_pkg::*;
#(
   parameter int SIMD         = DEF_SIMD,
   parameter int IP_PRECISION = DEF_PRECISION,
   parameter int IFM_CHANNELS = DEF_IFM_CHANNELS,
   parameter int IFM_WIDTH    = DEF_IFM_WIDTH,
   parameter int IFM_HEIGHT   = DEF_IFM_HEIGHT,
   parameter int KERNEL_DIM   = DEF_KERNEL_DIM,
   parameter int STRIDE       = DEF_STRIDE
) (
   input logic                         aclk,
   input logic                         aresetn,
   input logic                         s_axis_tvalid_i,
   input logic                         s_axis_tready_i,
   input logic [SIMD*IP_PRECISION-1:0] m_axis_tdata_i,
   input logic                         m_axis_tvalid_i,
   input logic                         m_axis_tready_i,
   input index_t                       oldest_pos_i
);

   localparam int     GROUPS    = IFM_CHANNELS / SIMD;
   localparam index_t DEPTH     = index_t'((KERNEL_DIM + STRIDE - 1) * IFM_WIDTH * GROUPS);
   localparam index_t LAST_BEAT = index_t'(IFM_HEIGHT * IFM_WIDTH * GROUPS - 1);

   index_t accepted;
   index_t occupancy;
   int     assert_errors = 0;

   // beats of the current frame, seen on the input handshake
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         accepted <= '0;
      end else if (s_axis_tvalid_i && s_axis_tready_i) begin
         accepted <= (accepted == LAST_BEAT) ? '0 : accepted + index_t'(1);
      end
   end

   assign occupancy = (accepted > oldest_pos_i) ? accepted - oldest_pos_i : '0;

   stall_hold: assert property (@(posedge aclk) disable iff (!aresetn)
      m_axis_tvalid_i && !m_axis_tready_i |=> m_axis_tvalid_i && $stable(m_axis_tdata_i))
      else begin
         assert_errors++;
         $error("output beat changed while stalled");
      end

   reset_quiet: assert property (@(posedge aclk) !aresetn |=> !m_axis_tvalid_i)
      else begin
         assert_errors++;
         $error("output valid high during reset");
      end

   buffer_bound: assert property (@(posedge aclk) disable iff (!aresetn) occupancy <= DEPTH)
      else begin
         assert_errors++;
         $error("line buffer overrun");
      end

endmodule

bind swu_top swu_chk #(
   .SIMD(SIMD), .IP_PRECISION(IP_PRECISION), .IFM_CHANNELS(IFM_CHANNELS),
   .IFM_WIDTH(IFM_WIDTH), .IFM_HEIGHT(IFM_HEIGHT), .KERNEL_DIM(KERNEL_DIM), .STRIDE(STRIDE)
) chk_i (
   .aclk(aclk), .aresetn(aresetn),
   .s_axis_tvalid_i(s_axis_tvalid_i), .s_axis_tready_i(s_axis_tready_o),
   .m_axis_tdata_i(m_axis_tdata_o), .m_axis_tvalid_i(m_axis_tvalid_o),
   .m_axis_tready_i(m_axis_tready_i), .oldest_pos_i(oldest_pos)
);

// ==== tests/swu_tb.sv ====
`timescale 1ns/100ps

module swu_tb
   import swu_pkg::*;
();

   localparam int BEAT_BITS    = DEF_SIMD * DEF_PRECISION;
   localparam int GROUPS       = DEF_IFM_CHANNELS / DEF_SIMD;
   localparam int OUT_W        = (DEF_IFM_WIDTH - DEF_KERNEL_DIM) / DEF_STRIDE + 1;
   localparam int OUT_H        = (DEF_IFM_HEIGHT - DEF_KERNEL_DIM) / DEF_STRIDE + 1;
   localparam int FRAME_BEATS  = DEF_IFM_HEIGHT * DEF_IFM_WIDTH * GROUPS;
   localparam int BUF_BEATS    = (DEF_KERNEL_DIM + DEF_STRIDE - 1) * DEF_IFM_WIDTH * GROUPS;
   localparam int TIMEOUT      = 5000;

   logic                 aclk = 1'b0;
   logic                 aresetn;
   logic [BEAT_BITS-1:0] s_tdata;
   logic                 s_tvalid;
   logic                 s_tready;
   logic [BEAT_BITS-1:0] m_tdata;
   logic                 m_tvalid;
   logic                 m_tready;

   logic [BEAT_BITS-1:0] stim[$];
   logic [BEAT_BITS-1:0] exp_q[$];
   int                   in_count  = 0;
   int                   ready_pct = 100;
   bit                   sending   = 1'b0;

   swu_top swu_top_i (
      .aclk(aclk), .aresetn(aresetn),
      .s_axis_tdata_i(s_tdata), .s_axis_tvalid_i(s_tvalid), .s_axis_tready_o(s_tready),
      .m_axis_tdata_o(m_tdata), .m_axis_tvalid_o(m_tvalid), .m_axis_tready_i(m_tready)
   );

   initial begin
      forever #4 aclk = ~aclk;
   end

   // output ready is redrawn on every falling edge
   initial begin
      m_tready = 1'b0;
      forever begin
         @(negedge aclk);
         m_tready = ($urandom_range(99) < ready_pct);
      end
   end

   ////////////////////////////////////////////////////////////
   // reporting
   ////////////////////////////////////////////////////////////

   task automatic abort_run(input string why);
      $display("ERROR at %0t: %s", $time, why);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected) begin
         $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, expected);
         abort_run("value check failed");
      end
   endtask

   // handshake monitors and the bound checker's failure count
   always @(posedge aclk) begin
      if (swu_top_i.chk_i.assert_errors != 0) begin
         abort_run("stream checker assertion failed");
      end
      if (aresetn && s_tvalid && s_tready) begin
         in_count++;
      end
      if (aresetn && m_tvalid && m_tready) begin
         if (exp_q.size() == 0) begin
            abort_run("output beat arrived with no beat expected");
         end else begin
            check_value("m_axis_tdata_o", 32'(m_tdata), 32'(exp_q.pop_front()));
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // stimulus and reference model
   ////////////////////////////////////////////////////////////

   // random frames and their expected windows in kh, kw, group order
   task automatic load_frames(input int frames);
      int base;
      int row;
      int col;
      stim.delete();
      for (int f = 0; f < frames; f++) begin
         base = f * FRAME_BEATS;
         for (int i = 0; i < FRAME_BEATS; i++) begin
            stim.push_back(BEAT_BITS'($urandom));
         end
         for (int oy = 0; oy < OUT_H; oy++) begin
            for (int ox = 0; ox < OUT_W; ox++) begin
               for (int kh = 0; kh < DEF_KERNEL_DIM; kh++) begin
                  for (int kw = 0; kw < DEF_KERNEL_DIM; kw++) begin
                     row = oy * DEF_STRIDE + kh;
                     col = ox * DEF_STRIDE + kw;
                     for (int cg = 0; cg < GROUPS; cg++) begin
                        exp_q.push_back(stim[base + (row * DEF_IFM_WIDTH + col) * GROUPS + cg]);
                     end
                  end
               end
            end
         end
      end
   endtask

   // called on a falling edge; valid stays up between beats unless a gap is drawn
   task automatic send_stim(input int gap_pct);
      int waited;
      sending = 1'b1;
      foreach (stim[i]) begin
         if ($urandom_range(99) < gap_pct) begin
            s_tvalid = 1'b0;
            @(negedge aclk);
         end
         s_tdata  = stim[i];
         s_tvalid = 1'b1;
         waited   = 0;
         while (!s_tready) begin
            @(negedge aclk);
            waited++;
            if (waited > TIMEOUT) abort_run("input beat never accepted");
         end
         @(negedge aclk);
      end
      s_tvalid = 1'b0;
      sending  = 1'b0;
   endtask

   task automatic wait_drained();
      int waited;
      waited = 0;
      while (sending || exp_q.size() != 0) begin
         @(negedge aclk);
         waited++;
         if (waited > TIMEOUT) abort_run("output stream stopped before the frame ended");
      end
   endtask

   // no beat may follow the last expected one within the pipeline depth
   task automatic check_idle();
      ready_pct = 100;
      repeat (8) begin
         @(negedge aclk);
         check_value("m_axis_tvalid_o", 32'(m_tvalid), 32'(0));
      end
   endtask

   ////////////////////////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////////////////////////

   task automatic stream_frames(input int frames, input int gap_pct, input int rdy_pct);
      ready_pct = rdy_pct;
      load_frames(frames);
      send_stim(gap_pct);
      wait_drained();
      check_idle();
   endtask

   task automatic single_frame();
      stream_frames(1, 0, 100);
   endtask

   task automatic output_backpressure();
      stream_frames(1, 0, 50);
   endtask

   task automatic input_gaps();
      stream_frames(1, 40, 100);
   endtask

   task automatic back_to_back_frames();
      stream_frames(2, 0, 100);
   endtask

   task automatic buffer_limit();
      int first_in;
      int waited;
      first_in  = in_count;
      ready_pct = 0;
      load_frames(1);
      fork
         send_stim(0);
      join_none
      waited = 0;
      while (s_tready) begin
         @(negedge aclk);
         waited++;
         if (waited > TIMEOUT) abort_run("input never stalled with the output blocked");
      end
      // input must stay stalled while the output is blocked
      repeat (20) @(negedge aclk);
      check_value("s_axis_tready_o", 32'(s_tready), 32'(0));
      check_value("accepted beats within buffer", 32'(in_count - first_in <= BUF_BEATS),
                  32'(1));
      ready_pct = 100;
      wait_drained();
      check_idle();
   endtask

   initial begin
      aresetn  = 1'b0;
      s_tdata  = '0;
      s_tvalid = 1'b0;
      void'($urandom(32'h2982_5884));
      repeat (8) @(negedge aclk);
      aresetn = 1'b1;
      @(negedge aclk);
      single_frame();
      output_backpressure();
      input_gaps();
      back_to_back_frames();
      buffer_limit();
      if (swu_top_i.chk_i.assert_errors == 0) begin
         $display("TESTBENCH PASSED");
         $finish;
      end else begin
         abort_run("stream checker assertions failed");
      end
   end

endmodule
